/* Bender.yml */
package:
  name: exe_cluster

sources:
  - hdl/exePkg.sv
  - hdl/alu.sv
  - hdl/exeLane.sv
  - hdl/exeDispatch.sv
  - hdl/wbCollector.sv
  - hdl/exeCluster.sv
  - target: simulation
    files:
      - tb/exeClusterTb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu
(
	input exePkg::aluOpT aluFn,
	input logic [31:0] opA,
	input logic [31:0] opB,
	output logic [31:0] result
);

	logic [4:0] shamt;
	logic ltSigned;
	logic ltUnsigned;

	assign shamt = opB[4:0]; // rv32 uses low five bits only
	assign ltSigned = $signed(opA) < $signed(opB);
	assign ltUnsigned = opA < opB;

	always_comb
	begin
		case (aluFn)
			exePkg::aluAdd:
				result = opA + opB;
			exePkg::aluSub:
				result = opA - opB;
			exePkg::aluAnd:
				result = opA & opB;
			exePkg::aluOr:
				result = opA | opB;
			exePkg::aluXor:
				result = opA ^ opB;
			exePkg::aluSll:
				result = opA << shamt;
			exePkg::aluSrl:
				result = opA >> shamt;
			exePkg::aluSra:
				result = $signed(opA) >>> shamt; // sign fill
			exePkg::aluSlt:
				result = {31'b0, ltSigned};
			exePkg::aluSltu:
				result = {31'b0, ltUnsigned};
			default:
				result = '0;
		endcase
	end

endmodule

/* hdl/exeCluster.sv */
`timescale 1ns/1ps

module exeCluster
#(
	parameter int NUM_LANES = 3,
	parameter int FIFO_DEPTH = 4
)
(
	input logic clk,
	input logic nrst,
	input logic issueReq,
	input exePkg::issueT issue,
	output logic issueAck,
	output logic wbReq,
	output exePkg::resultT wb,
	input logic wbAck
);

	logic [NUM_LANES-1:0] laneValid;
	exePkg::issueT laneOp; // shared by all lanes
	logic [NUM_LANES-1:0] resValid;
	exePkg::resultT laneRes [NUM_LANES];
	logic popDone; // credit back to dispatcher

	exeDispatch #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) dispatch0
	(
		.clk(clk),
		.nrst(nrst),
		.issueReq(issueReq),
		.issue(issue),
		.issueAck(issueAck),
		.popDone(popDone),
		.laneValid(laneValid),
		.laneOp(laneOp)
	);

	for (genvar i = 0; i < NUM_LANES; i++)
	begin : laneGen
		exeLane lane0
		(
			.clk(clk),
			.nrst(nrst),
			.valid(laneValid[i]),
			.op(laneOp),
			.resValid(resValid[i]),
			.res(laneRes[i])
		);
	end

	wbCollector #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) collector0
	(
		.clk(clk),
		.nrst(nrst),
		.resValid(resValid),
		.laneRes(laneRes),
		.wbReq(wbReq),
		.wb(wb),
		.wbAck(wbAck),
		.popDone(popDone)
	);

endmodule

/* hdl/exeDispatch.sv */
`timescale 1ns/1ps

module exeDispatch
#(
	parameter int NUM_LANES = 3,
	parameter int FIFO_DEPTH = 4
)
(
	input logic clk,
	input logic nrst,
	input logic issueReq,
	input exePkg::issueT issue,
	output logic issueAck,
	input logic popDone,
	output logic [NUM_LANES-1:0] laneValid,
	output exePkg::issueT laneOp
);

	localparam int CREDIT_W = exePkg::creditBits(FIFO_DEPTH);
	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [PTR_W-1:0] lanePtr; // next lane to receive an op
	logic [CREDIT_W-1:0] credit; // ops in lanes or fifo
	logic take;

	// ack low means the previous handshake has fully closed
	assign take = issueReq && !issueAck && (credit < CREDIT_W'(FIFO_DEPTH));

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			issueAck <= 1'b0;
			lanePtr <= '0;
			laneValid <= '0;
			credit <= '0;
		end
		else
		begin
			laneValid <= '0;
			if (take)
			begin
				issueAck <= 1'b1;
				laneValid[lanePtr] <= 1'b1;
				if (lanePtr == PTR_W'(NUM_LANES - 1))
					lanePtr <= '0;
				else
					lanePtr <= lanePtr + 1'b1;
			end
			else if (issueAck && !issueReq)
				issueAck <= 1'b0; // req withdrawn, close handshake
			// count the op when it enters a lane
			credit <= credit + CREDIT_W'(|laneValid) - CREDIT_W'(popDone);
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			laneOp <= issue; // issuer may change data once ack is seen
	end

	assert property (@(posedge clk) disable iff (!nrst)
		(credit == CREDIT_W'(FIFO_DEPTH)) |-> (laneValid == '0));

endmodule

/* hdl/exeLane.sv */
`timescale 1ns/1ps

module exeLane
(
	input logic clk,
	input logic nrst,
	input logic valid,
	input exePkg::issueT op,
	output logic resValid,
	output exePkg::resultT res
);

	// stage 5
	logic valid5;
	exePkg::issueT op5;
	logic [31:0] aluRes5;
	logic [31:0] link5;
	logic [31:0] auipc5;

	// stage 6
	logic valid6;
	logic [31:0] aluRes6;
	logic [31:0] link6;
	logic [31:0] uImm6;
	logic [31:0] auipc6;
	logic [4:0] rd6;
	logic we6;
	exePkg::wbSelT wbSel6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			valid5 <= 1'b0;
			valid6 <= 1'b0;
		end
		else
		begin
			valid5 <= valid;
			valid6 <= valid5;
		end
	end

	always_ff @(posedge clk)
	begin
		if (valid)
			op5 <= op;
	end

	alu alu0
	(
		.aluFn(op5.aluFn),
		.opA(op5.opA),
		.opB(op5.opB),
		.result(aluRes5)
	);

	assign link5 = op5.pc + 32'd4;
	assign auipc5 = op5.pc + op5.uImm;

	always_ff @(posedge clk)
	begin
		if (valid5)
		begin
			aluRes6 <= aluRes5;
			link6 <= link5;
			uImm6 <= op5.uImm;
			auipc6 <= auipc5;
			rd6 <= op5.rd;
			we6 <= op5.we;
			wbSel6 <= op5.wbSel;
		end
	end

	assign resValid = valid6;

	always_comb
	begin
		res.rd = rd6;
		res.we = we6;
		case (wbSel6)
			exePkg::wbLink:
				res.data = link6;
			exePkg::wbUpper:
				res.data = uImm6;
			exePkg::wbAuipc:
				res.data = auipc6;
			default:
				res.data = aluRes6;
		endcase
	end

	// fixed latency with rd and we carried through both stages
	assert property (@(posedge clk) disable iff (!nrst)
		(resValid == $past(valid, 2))
		&& (!resValid || (res.rd == $past(op.rd, 2) && res.we == $past(op.we, 2))));

endmodule

/* hdl/exePkg.sv */
package exePkg;

	// ALU function select
	typedef enum logic [3:0]
	{
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluAnd  = 4'd2,
		aluOr   = 4'd3,
		aluXor  = 4'd4,
		aluSll  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluSlt  = 4'd8,
		aluSltu = 4'd9
	} aluOpT;

	// writeback source
	typedef enum logic [1:0]
	{
		wbAlu   = 2'd0, // alu result
		wbLink  = 2'd1, // pc+4
		wbUpper = 2'd2, // lui
		wbAuipc = 2'd3  // pc + upper imm
	} wbSelT;

	// one decoded operation, operands already read
	typedef struct packed
	{
		logic [31:0] opA;
		logic [31:0] opB;
		logic [31:0] uImm;
		logic [31:0] pc;
		logic [4:0] rd;
		aluOpT aluFn;
		wbSelT wbSel;
		logic we;
	} issueT;

	typedef struct packed
	{
		logic [4:0] rd;
		logic [31:0] data;
		logic we;
	} resultT;

	// counter width holding 0 up to depth inclusive
	function automatic int creditBits(input int depth);
		return $clog2(depth + 1);
	endfunction

endpackage

/* hdl/wbCollector.sv */
`timescale 1ns/1ps

module wbCollector
#(
	parameter int NUM_LANES = 3,
	parameter int FIFO_DEPTH = 4
)
(
	input logic clk,
	input logic nrst,
	input logic [NUM_LANES-1:0] resValid,
	input exePkg::resultT laneRes [NUM_LANES],
	output logic wbReq,
	output exePkg::resultT wb,
	input logic wbAck,
	output logic popDone
);

	localparam int COUNT_W = exePkg::creditBits(FIFO_DEPTH);
	localparam int IDX_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	exePkg::resultT mem [FIFO_DEPTH];
	logic [IDX_W-1:0] wrPtr;
	logic [IDX_W-1:0] rdPtr;
	logic [COUNT_W-1:0] count;
	exePkg::resultT inRes;
	logic push;
	logic pop;

	function automatic logic [IDX_W-1:0] nextIdx(input logic [IDX_W-1:0] idx);
		return (idx == IDX_W'(FIFO_DEPTH - 1)) ? '0 : idx + 1'b1;
	endfunction

	// lanes finish in issue order, never two at once
	always_comb
	begin
		inRes = '0;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (resValid[i])
				inRes = laneRes[i];
		end
	end

	assign push = |resValid;
	assign pop = wbReq && wbAck; // ack seen, head leaves

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= inRes;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			wbReq <= 1'b0;
			popDone <= 1'b0;
		end
		else
		begin
			popDone <= pop;
			if (push)
				wrPtr <= nextIdx(wrPtr);
			if (pop)
				rdPtr <= nextIdx(rdPtr);
			count <= count + COUNT_W'(push) - COUNT_W'(pop);
			if (pop)
				wbReq <= 1'b0;
			else if (!wbReq && !wbAck && (count != '0))
				wbReq <= 1'b1; // previous ack has fallen
		end
	end

	assign wb = mem[rdPtr]; // head stays put until popped

	assert property (@(posedge clk) disable iff (!nrst) push |-> (count < COUNT_W'(FIFO_DEPTH)));
	assert property (@(posedge clk) disable iff (!nrst) $onehot0(resValid));

endmodule

/* list.f */
hdl/exePkg.sv
hdl/alu.sv
hdl/exeLane.sv
hdl/exeDispatch.sv
hdl/wbCollector.sv
hdl/exeCluster.sv
tb/exeClusterTb.sv

/* tb/exeCases.txt */
// aluFn wbSel rd we opA opB uImm pc expectedData, all hex
// aluFn 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra 8 slt 9 sltu
// wbSel 0 alu 1 link 2 upper 3 auipc
0 0 01 1 00000005 00000007 00000000 00000000 0000000c
0 0 02 1 ffffffff 00000001 00000000 00000000 00000000
1 0 03 1 00000010 00000003 00000000 00000000 0000000d
1 0 04 1 00000003 00000010 00000000 00000000 fffffff3
2 0 05 1 f0f0f0f0 0ff00ff0 00000000 00000000 00f000f0
3 0 06 1 f0f0f0f0 0ff00ff0 00000000 00000000 fff0fff0
4 0 07 1 f0f0f0f0 0ff00ff0 00000000 00000000 ff00ff00
5 0 08 1 00000001 00000004 00000000 00000000 00000010
5 0 09 1 00000003 00000024 00000000 00000000 00000030
6 0 0a 1 80000000 00000004 00000000 00000000 08000000
7 0 0b 1 80000000 00000004 00000000 00000000 f8000000
7 0 0c 1 40000000 00000004 00000000 00000000 04000000
7 0 0d 1 f0000000 0000001f 00000000 00000000 ffffffff
8 0 0e 1 ffffffff 00000001 00000000 00000000 00000001
9 0 0f 1 ffffffff 00000001 00000000 00000000 00000000
8 0 10 1 00000001 ffffffff 00000000 00000000 00000000
9 0 11 1 00000001 ffffffff 00000000 00000000 00000001
8 0 12 1 00000005 00000005 00000000 00000000 00000000
0 1 13 1 00000011 00000022 00000000 00001000 00001004
0 1 14 1 00000000 00000000 00000000 fffffffc 00000000
0 2 15 1 00000001 00000002 12345000 00000040 12345000
0 3 16 1 00000000 00000000 00010000 00002000 00012000
0 3 17 1 00000000 00000000 80000000 80000000 00000000
0 0 00 0 00000002 00000002 00000000 00000000 00000004
4 0 18 1 12345678 12345678 00000000 00000000 00000000
2 0 19 1 deadbeef ffffffff 00000000 00000000 deadbeef
1 0 1a 1 00000000 00000001 00000000 00000000 ffffffff
6 0 1b 1 ffffffff 0000001f 00000000 00000000 00000001
5 0 1c 1 00000001 0000001f 00000000 00000000 80000000
0 0 1d 1 7fffffff 00000001 00000000 00000000 80000000
7 0 1e 1 87654321 00000000 00000000 00000000 87654321
9 0 1f 1 00000007 00000007 00000000 00000000 00000000
0 2 1f 1 00000000 00000000 fffff000 00000100 fffff000

/* tb/exeClusterTb.sv */
`timescale 1ns/1ps

module exeClusterTb;

	localparam int NUM_LANES = 3;
	localparam int FIFO_DEPTH = 4;
	localparam int FIELDS = 9; // words per case line
	localparam int MAX_CASES = 64;
	localparam int CLK_HALF = 50;

	logic clk;
	logic nrst;
	logic issueReq;
	exePkg::issueT issue;
	logic issueAck;
	logic wbReq;
	exePkg::resultT wb;
	logic wbAck;

	logic [31:0] caseMem [MAX_CASES*FIELDS];
	int numCases;
	int timeoutLimit;
	int cycles;
	int errorCount;
	int checkCount;
	int issuedCount; // rising edges of issueAck
	int wbCount; // writebacks taken by the receiver
	int wbSeen; // rising edges of wbReq
	int stallCycles;
	int unsigned lcgState;

	// previous negedge samples for the handshake monitor
	logic prevIssueReq;
	logic prevIssueAck;
	logic prevWbReq;
	logic prevWbAck;
	exePkg::resultT prevWb;

	exeCluster #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) dut0
	(
		.clk(clk),
		.nrst(nrst),
		.issueReq(issueReq),
		.issue(issue),
		.issueAck(issueAck),
		.wbReq(wbReq),
		.wb(wb),
		.wbAck(wbAck)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#CLK_HALF clk = ~clk;
	end

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16; // upper bits are less periodic
	endfunction

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %s: got %0h, expected %0h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic reportError(input string msg);
		errorCount++;
		$display("error at %0t: %s", $time, msg);
	endtask

	// one four-phase issue handshake for case idx
	task automatic issueCase(input int idx);
		exePkg::issueT op;
		int base;
		int waits;
		base = idx * FIELDS;
		waits = 0;
		op.aluFn = exePkg::aluOpT'(caseMem[base][3:0]);
		op.wbSel = exePkg::wbSelT'(caseMem[base + 1][1:0]);
		op.rd = caseMem[base + 2][4:0];
		op.we = caseMem[base + 3][0];
		op.opA = caseMem[base + 4];
		op.opB = caseMem[base + 5];
		op.uImm = caseMem[base + 6];
		op.pc = caseMem[base + 7];
		issue = op; // data settles together with req
		issueReq = 1'b1;
		do
		begin
			@(posedge clk);
			#1;
			waits++;
		end
		while (!issueAck);
		stallCycles += waits - 1; // first edge is the normal take
		issueReq = 1'b0;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (issueAck);
	endtask

	task automatic driveIssues();
		for (int i = 0; i < numCases; i++)
			issueCase(i);
	endtask

	// wait for wbReq, check against case idx, then ack after a random delay
	task automatic receiveOne(input int idx);
		int base;
		int delay;
		base = idx * FIELDS;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!wbReq);
		checkValue("wb.rd", wb.rd, caseMem[base + 2][4:0]);
		checkValue("wb.we", wb.we, caseMem[base + 3][0]);
		checkValue("wb.data", wb.data, caseMem[base + 8]);
		delay = nextRandom() % 7;
		repeat (delay)
		begin
			@(posedge clk);
			#1;
		end
		wbAck = 1'b1;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (wbReq);
		wbAck = 1'b0;
		wbCount++;
	endtask

	task automatic collectWritebacks();
		for (int i = 0; i < numCases; i++)
			receiveOne(i);
	endtask

	// handshake order sampled mid-cycle where everything is settled
	always @(negedge clk)
	begin
		if (nrst)
		begin
			if (!prevIssueAck && issueAck && !prevIssueReq)
				reportError("issueAck rose while issueReq was low");
			if (prevIssueAck && !issueAck && prevIssueReq)
				reportError("issueAck fell while issueReq was still high");
			if (!prevWbReq && wbReq && prevWbAck)
				reportError("wbReq rose before wbAck had fallen");
			if (prevWbReq && !wbReq && !prevWbAck)
				reportError("wbReq fell without a wbAck");
			if (!prevIssueAck && issueAck)
				issuedCount++;
			if (!prevWbReq && wbReq)
				wbSeen++;
			if (prevWbReq && wbReq)
				checkValue("wb", wb, prevWb); // held while req is up
		end
		prevIssueReq = issueReq;
		prevIssueAck = issueAck;
		prevWbReq = wbReq;
		prevWbAck = wbAck;
		prevWb = wb;
	end

	// watchdog
	initial
	begin
		cycles = 0;
		@(posedge nrst);
		while (cycles < timeoutLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles, %0d of %0d writebacks seen",
			timeoutLimit, wbCount, numCases);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		nrst = 1'b0;
		issueReq = 1'b0;
		issue = '0;
		wbAck = 1'b0;
		errorCount = 0;
		checkCount = 0;
		issuedCount = 0;
		wbCount = 0;
		wbSeen = 0;
		stallCycles = 0;
		lcgState = 71;
		prevIssueReq = 1'b0;
		prevIssueAck = 1'b0;
		prevWbReq = 1'b0;
		prevWbAck = 1'b0;
		prevWb = '0;

		$readmemh("tb/exeCases.txt", caseMem);
		numCases = 0;
		while (numCases < MAX_CASES && !$isunknown(caseMem[numCases * FIELDS]))
			numCases++;
		timeoutLimit = 40 * numCases + 50;
		if (numCases == 0)
			reportError("no cases could be read from tb/exeCases.txt");

		repeat (2) @(posedge clk);
		#1;
		checkValue("issueAck", issueAck, 1'b0);
		checkValue("wbReq", wbReq, 1'b0);
		nrst = 1'b1;
		@(posedge clk);
		#1;
		checkValue("issueAck", issueAck, 1'b0); // still idle after reset
		checkValue("wbReq", wbReq, 1'b0);

		fork
			driveIssues();
			collectWritebacks();
		join

		// nothing may follow the last case
		repeat (10)
		begin
			@(posedge clk);
			#1;
			if (wbReq)
				reportError("extra writeback after the last case");
		end
		checkValue("issued count", issuedCount, numCases);
		checkValue("writeback count", wbSeen, numCases);
		if (stallCycles == 0)
			reportError("issueAck never stalled so the credit limit was not exercised");

		$display("issue stall cycles: %0d", stallCycles);
		$display("cases %0d, checks %0d, errors %0d", numCases, checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
